// File: rtl/rv32i_types.sv
`default_nettype none

package rv32i_types;

	localparam int XLEN      = 32; // integer register width
	localparam int NUM_REGS  = 32; // x0..x31
	localparam int REG_IDX_W = $clog2(NUM_REGS);
	localparam int SHAMT_W   = 5; // rv32 shifts use 5 bits

	// funct7 encodings, bit 30 picks sub / sra
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	typedef logic [XLEN-1:0]      rv32i_word; // data, instr, imm
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [2:0]           funct3_t;
	typedef logic [6:0]           funct7_t;

	// only the classes this core executes
	typedef enum logic [6:0] {
		op_imm = 7'b0010011, // addi, slti, ... srai
		op_reg = 7'b0110011, // add, sub, ... and
		op_lui = 7'b0110111  // load upper immediate
	} rv32i_opcode;

	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_sll  = 4'd2,
		alu_slt  = 4'd3,
		alu_sltu = 4'd4,
		alu_xor  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_or   = 4'd8,
		alu_and  = 4'd9
	} alu_op_t;

	// decoded instruction, decode -> execute
	typedef struct packed {
		logic        valid;
		rv32i_opcode opcode;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		alu_op_t     alu_op;
		logic        use_imm; // imm replaces rs2
		rv32i_word   imm;     // sext i-imm or u-imm
	} pci_t;

	// execute -> writeback
	typedef struct packed {
		logic      valid;
		reg_idx_t  rd;
		rv32i_word data;
	} exec_result_t;

endpackage

`default_nettype wire

// File: rtl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   instr_valid,
	input  rv32i_types::rv32i_word instr,
	output rv32i_types::pci_t      dec_pci,
	output logic                   illegal
);

	rv32i_types::funct3_t   funct3;
	rv32i_types::funct7_t   funct7;
	rv32i_types::rv32i_word i_imm;
	rv32i_types::rv32i_word u_imm;
	logic                   f7_base;
	logic                   f7_alt;
	logic                   legal;
	rv32i_types::pci_t      pci_d;

	// alt picks sub or sra for its funct3
	function automatic rv32i_types::alu_op_t alu_of_f3(
		input rv32i_types::funct3_t f3,
		input logic                 alt
	);
		rv32i_types::alu_op_t op;
		case (f3)
			3'b000:  op = alt ? rv32i_types::alu_sub : rv32i_types::alu_add;
			3'b001:  op = rv32i_types::alu_sll;
			3'b010:  op = rv32i_types::alu_slt;
			3'b011:  op = rv32i_types::alu_sltu;
			3'b100:  op = rv32i_types::alu_xor;
			3'b101:  op = alt ? rv32i_types::alu_sra : rv32i_types::alu_srl;
			3'b110:  op = rv32i_types::alu_or;
			default: op = rv32i_types::alu_and;
		endcase
		return op;
	endfunction

	assign funct3  = instr[14:12];
	assign funct7  = instr[31:25];
	assign i_imm   = {{20{instr[31]}}, instr[31:20]}; // sign extended
	assign u_imm   = {instr[31:12], 12'h000};       // low 12 bits zero
	assign f7_base = (funct7 == rv32i_types::F7_BASE);
	assign f7_alt  = (funct7 == rv32i_types::F7_ALT);

	always_comb
	begin
		pci_d        = '0;
		pci_d.opcode = rv32i_types::rv32i_opcode'(instr[6:0]);
		pci_d.rd     = instr[11:7];
		pci_d.rs1    = instr[19:15];
		pci_d.rs2    = instr[24:20];
		pci_d.imm    = i_imm;
		legal        = 1'b1;
		case (pci_d.opcode)
			rv32i_types::op_imm:
			begin
				pci_d.use_imm = 1'b1;
				pci_d.rs2     = '0; // rs2 slot holds imm bits here
				// bit 30 is imm for addi and only picks srai on funct3 5
				pci_d.alu_op  = alu_of_f3(funct3, funct7[5] && (funct3 == 3'b101));
				if (funct3 == 3'b001)
					legal = f7_base; // slli
				else if (funct3 == 3'b101)
					legal = f7_base || f7_alt; // srli / srai
			end
			rv32i_types::op_reg:
			begin
				pci_d.alu_op = alu_of_f3(funct3, funct7[5]);
				// alt encoding only exists for sub and sra
				legal = f7_base || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
			end
			rv32i_types::op_lui:
			begin
				pci_d.use_imm = 1'b1;
				pci_d.imm     = u_imm;
				pci_d.rs1     = '0; // no sources
				pci_d.rs2     = '0;
				pci_d.alu_op  = rv32i_types::alu_add;
			end
			default: legal = 1'b0; // loads, stores, branches, ...
		endcase
		pci_d.valid = instr_valid && legal;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			dec_pci <= '0;
			illegal <= 1'b0;
		end
		else
		begin
			dec_pci <= pci_d;
			illegal <= instr_valid && !legal; // one cycle pulse per bad word
		end
	end

	// bit 30 of an addi imm never turns into sub
	a_sub_op_only : assert property (@(posedge clk) disable iff (!rst_n)
		(dec_pci.valid && dec_pci.alu_op == rv32i_types::alu_sub) |->
			(dec_pci.opcode == rv32i_types::op_reg))
		else $error("decoder: sub decoded outside of op");

endmodule

`default_nettype wire

// File: rtl/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
	input  logic                      clk,
	input  logic                      rst_n,
	input  rv32i_types::pci_t         dec_pci,
	output rv32i_types::reg_idx_t     rf_rs1_addr,
	output rv32i_types::reg_idx_t     rf_rs2_addr,
	input  rv32i_types::rv32i_word    rf_rs1_data,
	input  rv32i_types::rv32i_word    rf_rs2_data,
	input  rv32i_types::exec_result_t wb_res,
	output rv32i_types::exec_result_t ex_res
);

	logic                            fwd_rs1;
	logic                            fwd_rs2;
	rv32i_types::rv32i_word          op_a;
	rv32i_types::rv32i_word          rs2_val;
	rv32i_types::rv32i_word          op_b;
	logic [rv32i_types::SHAMT_W-1:0] shamt;
	rv32i_types::rv32i_word          alu_out;

	assign rf_rs1_addr = dec_pci.rs1; // combinational read in commit_regfile
	assign rf_rs2_addr = dec_pci.rs2;

	// result of the previous instr is still waiting for its write edge
	assign fwd_rs1 = wb_res.valid && (dec_pci.rs1 != '0) && (wb_res.rd == dec_pci.rs1);
	assign fwd_rs2 = wb_res.valid && (dec_pci.rs2 != '0) && (wb_res.rd == dec_pci.rs2);

	assign op_a    = fwd_rs1 ? wb_res.data : rf_rs1_data;
	assign rs2_val = fwd_rs2 ? wb_res.data : rf_rs2_data;
	assign op_b    = dec_pci.use_imm ? dec_pci.imm : rs2_val;
	assign shamt   = op_b[rv32i_types::SHAMT_W-1:0]; // upper bits ignored

	always_comb
	begin
		case (dec_pci.alu_op)
			rv32i_types::alu_add:  alu_out = op_a + op_b;
			rv32i_types::alu_sub:  alu_out = op_a - op_b;
			rv32i_types::alu_sll:  alu_out = op_a << shamt;
			rv32i_types::alu_slt:
				alu_out = rv32i_types::rv32i_word'($signed(op_a) < $signed(op_b));
			rv32i_types::alu_sltu: alu_out = rv32i_types::rv32i_word'(op_a < op_b);
			rv32i_types::alu_xor:  alu_out = op_a ^ op_b;
			rv32i_types::alu_srl:  alu_out = op_a >> shamt;
			rv32i_types::alu_sra:
				alu_out = rv32i_types::rv32i_word'($signed(op_a) >>> shamt); // keeps sign
			rv32i_types::alu_or:   alu_out = op_a | op_b;
			rv32i_types::alu_and:  alu_out = op_a & op_b;
			default:               alu_out = op_a + op_b;
		endcase
		// lui: immediate straight through, no rs1 add
		if (dec_pci.opcode == rv32i_types::op_lui)
			alu_out = dec_pci.imm;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			ex_res <= '0;
		else
		begin
			ex_res.valid <= dec_pci.valid;
			ex_res.rd    <= dec_pci.rd;
			ex_res.data  <= alu_out;
		end
	end

	// catches an unwritten reg or a broken bypass reaching writeback
	a_res_known : assert property (@(posedge clk) disable iff (!rst_n)
		ex_res.valid |-> !$isunknown(ex_res.data))
		else $error("alu_exec: valid ex_res with unknown data");

endmodule

`default_nettype wire

// File: rtl/commit_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module commit_regfile (
	input  logic                      clk,
	input  logic                      rst_n,
	input  rv32i_types::exec_result_t ex_res,
	input  rv32i_types::reg_idx_t     rf_rs1_addr,
	input  rv32i_types::reg_idx_t     rf_rs2_addr,
	output rv32i_types::rv32i_word    rf_rs1_data,
	output rv32i_types::rv32i_word    rf_rs2_data,
	output rv32i_types::exec_result_t wb_res,
	output logic                      commit,
	output rv32i_types::reg_idx_t     commit_rd,
	output rv32i_types::rv32i_word    commit_data,
	input  rv32i_types::reg_idx_t     dbg_addr,
	output rv32i_types::rv32i_word    dbg_data
);

	rv32i_types::rv32i_word regs [rv32i_types::NUM_REGS];
	logic                   wr_en;

	// x0 never written, so entry 0 stays at its reset value
	assign wr_en = ex_res.valid && (ex_res.rd != '0);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			// architectural state starts at zero
			for (int i = 0; i < rv32i_types::NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
			regs[ex_res.rd] <= ex_res.data;
	end

	// read ports, combinational, see writes of earlier edges only
	assign rf_rs1_data = regs[rf_rs1_addr];
	assign rf_rs2_data = regs[rf_rs2_addr];
	assign dbg_data    = regs[dbg_addr]; // debug sweep from tb

	// pending write, alu_exec bypasses from this
	assign wb_res = ex_res;

	// commit high in the cycle of the write edge
	assign commit      = ex_res.valid;
	assign commit_rd   = ex_res.rd;
	assign commit_data = (ex_res.rd == '0) ? '0 : ex_res.data; // x0 reports 0

	// x0 reads zero on every port, guards the write gating above
	a_x0_zero : assert property (@(posedge clk) disable iff (!rst_n)
		(rf_rs1_addr != '0 || rf_rs1_data == '0) &&
		(rf_rs2_addr != '0 || rf_rs2_data == '0) &&
		(dbg_addr != '0 || dbg_data == '0))
		else $error("commit_regfile: x0 read returned nonzero");

endmodule

`default_nettype wire

// File: rtl/op_imm_core.sv
`timescale 1ns/1ps
`default_nettype none

module op_imm_core (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   instr_valid,
	input  rv32i_types::rv32i_word instr,
	output logic                   illegal,
	output logic                   commit,
	output rv32i_types::reg_idx_t  commit_rd,
	output rv32i_types::rv32i_word commit_data,
	input  rv32i_types::reg_idx_t  dbg_addr,
	output rv32i_types::rv32i_word dbg_data
);

	rv32i_types::pci_t         dec_pci; // decode -> execute
	rv32i_types::exec_result_t ex_res;  // execute -> writeback
	rv32i_types::exec_result_t wb_res;  // bypass path back
	rv32i_types::reg_idx_t     rf_rs1_addr;
	rv32i_types::reg_idx_t     rf_rs2_addr;
	rv32i_types::rv32i_word    rf_rs1_data;
	rv32i_types::rv32i_word    rf_rs2_data;

	decoder i_decoder (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.dec_pci     (dec_pci),
		.illegal     (illegal)
	);

	alu_exec i_alu_exec (
		.clk         (clk),
		.rst_n       (rst_n),
		.dec_pci     (dec_pci),
		.rf_rs1_addr (rf_rs1_addr),
		.rf_rs2_addr (rf_rs2_addr),
		.rf_rs1_data (rf_rs1_data),
		.rf_rs2_data (rf_rs2_data),
		.wb_res      (wb_res),
		.ex_res      (ex_res)
	);

	commit_regfile i_commit_regfile (
		.clk         (clk),
		.rst_n       (rst_n),
		.ex_res      (ex_res),
		.rf_rs1_addr (rf_rs1_addr),
		.rf_rs2_addr (rf_rs2_addr),
		.rf_rs1_data (rf_rs1_data),
		.rf_rs2_data (rf_rs2_data),
		.wb_res      (wb_res),
		.commit      (commit),
		.commit_rd   (commit_rd),
		.commit_data (commit_data),
		.dbg_addr    (dbg_addr),
		.dbg_data    (dbg_data)
	);

endmodule

`default_nettype wire

// File: tb/reg_checker.sv
`timescale 1ns/1ps
`default_nettype none

module reg_checker (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   instr_valid,
	input  rv32i_types::rv32i_word instr,
	input  int                     row_idx,
	input  logic                   row_ill,
	input  logic                   illegal,
	input  logic                   commit,
	input  rv32i_types::reg_idx_t  commit_rd,
	input  rv32i_types::rv32i_word commit_data,
	input  logic                   sweep_en,
	input  rv32i_types::reg_idx_t  dbg_addr,
	input  rv32i_types::rv32i_word dbg_data,
	output logic                   busy,
	output int                     err_count,
	output int                     tests_run,
	output int                     tests_failed
);

	typedef struct packed {
		logic [31:0]            due; // checker cycle the pulse belongs to
		logic [31:0]            row;
		rv32i_types::reg_idx_t  rd;
		rv32i_types::rv32i_word data;
	} expect_t;

	rv32i_types::rv32i_word model [rv32i_types::NUM_REGS]; // architectural copy
	expect_t                ill_q[$];
	expect_t                com_q[$];
	logic [31:0]            cyc;
	logic                   row_ok;
	logic                   sweep_ok;

	// rv32i rules for op-imm, op and lui, ok low for anything else
	function automatic void model_exec(input rv32i_types::rv32i_word ins,
		input rv32i_types::rv32i_word a, input rv32i_types::rv32i_word rs2v,
		output logic ok, output rv32i_types::rv32i_word res);
		rv32i_types::rv32i_word b;
		logic [4:0]             sh;
		logic [6:0]             f7;
		logic                   alt;
		f7  = ins[31:25];
		alt = (f7 == 7'h20);
		b   = (ins[6:0] == 7'b0110011) ? rs2v : {{20{ins[31]}}, ins[31:20]};
		sh  = b[4:0]; // shift amount, rest ignored
		case (ins[6:0])
			7'b0010011: ok = (ins[14:12] == 3'd1) ? (f7 == 7'h00) :
				(ins[14:12] == 3'd5) ? (f7 == 7'h00 || alt) : 1'b1;
			7'b0110011: ok = (f7 == 7'h00) || (alt && (ins[14:12] == 3'd0 || ins[14:12] == 3'd5));
			7'b0110111: ok = 1'b1;
			default:    ok = 1'b0;
		endcase
		case (ins[14:12])
			3'd0:    res = (alt && ins[5]) ? a - b : a + b; // sub only in OP
			3'd1:    res = a << sh;
			3'd2:    res = {31'b0, $signed(a) < $signed(b)};
			3'd3:    res = {31'b0, a < b};
			3'd4:    res = a ^ b;
			3'd5:    res = (a >> sh) | ((alt && a[31]) ? ~(32'hffffffff >> sh) : 32'h0);
			3'd6:    res = a | b;
			default: res = a & b;
		endcase
		if (ins[6:0] == 7'b0110111)
			res = {ins[31:12], 12'h000}; // lui
	endfunction

	task automatic check_val(input string name, input rv32i_types::rv32i_word exp,
		input rv32i_types::rv32i_word got);
		if (got !== exp)
		begin
			$display("ERROR t=%0t %s expected %h got %h", $time, name, exp, got);
			err_count++;
			row_ok = 1'b0;
		end
	endtask

	task automatic complain(input string what);
		$display("t=%0t %s", $time, what);
		err_count++;
	endtask

	task automatic end_row(input string label);
		tests_run++;
		if (!row_ok)
			tests_failed++;
		$display("%s: %s", label, row_ok ? "ok" : "mismatch");
	endtask

	task automatic accept_issue();
		logic                   ok;
		rv32i_types::rv32i_word res;
		expect_t                e;
		model_exec(instr, model[instr[19:15]], model[instr[24:20]], ok, res);
		if (ok == row_ill)
			complain($sformatf("row %0d has a class in the table that the ISA disagrees with", row_idx));
		e.row  = row_idx;
		e.rd   = instr[11:7];
		e.data = (e.rd == '0) ? '0 : res; // x0 commits show 0
		e.due  = ok ? cyc + 2 : cyc + 1;
		if (ok)
		begin
			com_q.push_back(e);
			if (e.rd != '0)
				model[e.rd] = res; // in order, so update at issue
		end
		else
			ill_q.push_back(e);
	endtask

	// negedge sampling, DUT outputs and tb drives are both settled here
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			foreach (model[r])
				model[r] = '0;
			ill_q.delete();
			com_q.delete();
			cyc          = '0;
			busy         = 1'b0;
			err_count    = 0;
			tests_run    = 0;
			tests_failed = 0;
		end
		else
		begin
			cyc    = cyc + 1;
			row_ok = 1'b1;
			if (ill_q.size() != 0 && ill_q[0].due == cyc)
			begin
				check_val("illegal", 32'd1, 32'(illegal));
				end_row($sformatf("row %0d", ill_q[0].row));
				void'(ill_q.pop_front());
			end
			else if (illegal !== 1'b0)
				complain("illegal pulsed although no bad word was issued a cycle ago");
			row_ok = 1'b1;
			if (com_q.size() != 0 && com_q[0].due == cyc)
			begin
				check_val("commit", 32'd1, 32'(commit));
				check_val("commit_rd", 32'(com_q[0].rd), 32'(commit_rd));
				check_val("commit_data", com_q[0].data, commit_data);
				end_row($sformatf("row %0d", com_q[0].row));
				void'(com_q.pop_front());
			end
			else if (commit !== 1'b0)
				complain("commit pulsed although no instruction was due to retire");
			if (sweep_en)
			begin
				row_ok = 1'b1;
				if (dbg_addr == '0)
					sweep_ok = 1'b1;
				check_val($sformatf("dbg_data[x%0d]", dbg_addr), model[dbg_addr], dbg_data);
				sweep_ok = sweep_ok && row_ok;
				row_ok   = sweep_ok;
				if (dbg_addr == 5'd31)
					end_row("register sweep");
			end
			if (instr_valid)
				accept_issue();
			busy = (ill_q.size() != 0) || (com_q.size() != 0);
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_op_imm_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_op_imm_core;

	typedef struct packed {
		rv32i_types::rv32i_word insn;
		logic                   ill; // 1 expects illegal and 0 a commit
	} row_t;

	logic                   clk;
	logic                   rst_n;
	logic                   instr_valid;
	rv32i_types::rv32i_word instr;
	logic                   illegal;
	logic                   commit;
	rv32i_types::reg_idx_t  commit_rd;
	rv32i_types::rv32i_word commit_data;
	rv32i_types::reg_idx_t  dbg_addr;
	rv32i_types::rv32i_word dbg_data;
	int                     row_idx;
	logic                   row_ill;
	logic                   sweep_en;
	logic                   busy;
	int                     err_count;
	int                     tests_run;
	int                     tests_failed;
	row_t                   rows[$];
	integer                 seed;
	int                     gap;
	int                     wait_cnt;

	op_imm_core i_op_imm_core (.*);
	reg_checker i_reg_checker (.*);

	always #2 clk = ~clk; // 4 ns period

	function automatic rv32i_types::rv32i_word enc_i(int imm, int rs1, int f3, int rd);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
	endfunction

	function automatic rv32i_types::rv32i_word enc_r(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	task automatic add_row(input rv32i_types::rv32i_word w, input int ill);
		row_t r;
		r.insn = w;
		r.ill  = (ill != 0);
		rows.push_back(r);
	endtask

	initial
	begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		dbg_addr    = '0;
		row_idx     = 0;
		row_ill     = 1'b0;
		sweep_en    = 1'b0;
		seed        = 32'h6141;
		add_row(enc_i(5, 0, 0, 1), 0);          // addi x1, x0, 5
		add_row(enc_i(-3, 1, 0, 2), 0);         // reads x1 through bypass
		add_row(enc_i(-1, 2, 2, 3), 0);         // slti with negative imm
		add_row(enc_i(-1, 2, 3, 4), 0);         // sltiu where -1 is max unsigned
		add_row(enc_i(-8, 0, 0, 5), 0);
		add_row(enc_i(-1, 5, 2, 6), 0);         // -8 < -1 signed
		add_row(enc_i('h0f0, 5, 4, 7), 0);      // xori
		add_row(enc_i('h700, 1, 6, 8), 0);      // ori
		add_row(enc_i('h7f3, 5, 7, 9), 0);      // andi
		add_row(enc_i(4, 1, 1, 10), 0);         // slli
		add_row(enc_i(4, 5, 5, 11), 0);         // srli zero fill
		add_row(enc_i('h402, 5, 5, 12), 0);     // srai sign fill
		add_row(32'h123456b7, 0);               // lui x13, 0x12345
		add_row(enc_r(0, 1, 13, 0, 14), 0);     // add with x13 bypassed
		add_row(enc_r('h20, 14, 1, 0, 15), 0);  // sub with x14 bypassed on rs2
		add_row(enc_r(0, 14, 1, 1, 16), 0);     // sll uses only x14[4:0]
		add_row(enc_r(0, 1, 5, 2, 17), 0);      // slt
		add_row(enc_r(0, 1, 5, 3, 18), 0);      // sltu
		add_row(enc_r('h20, 14, 5, 5, 19), 0);  // sra
		add_row(enc_r(0, 14, 5, 5, 20), 0);     // srl
		add_row(enc_r(0, 5, 13, 4, 21), 0);     // xor
		add_row(enc_r(0, 9, 8, 6, 22), 0);      // or
		add_row(enc_r(0, 5, 13, 7, 23), 0);     // and
		add_row(enc_i(7, 1, 0, 0), 0);          // addi to x0
		add_row(32'h0000a283, 1);               // lw is not supported
		add_row(32'h00208063, 1);               // beq
		add_row(enc_r(1, 2, 1, 0, 24), 1);      // mul encoding has a bad funct7
		add_row(enc_r(0, 2, 1, 0, 0), 0);       // add to x0

		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int i = 0; i < rows.size(); i++)
		begin
			@(posedge clk);
			#1;
			instr       = rows[i].insn;
			instr_valid = 1'b1;
			row_idx     = i;
			row_ill     = rows[i].ill;
			if (i % 5 == 4)
			begin
				gap = ($random(seed) & 3) + 1; // 1..4 idle cycles
				repeat (gap)
				begin
					@(posedge clk);
					#1;
					instr_valid = 1'b0;
				end
			end
		end
		@(posedge clk);
		#1;
		instr_valid = 1'b0;

		wait_cnt = 0;
		while (busy && wait_cnt < 50)
		begin
			@(posedge clk);
			wait_cnt++;
		end

		if (busy)
		begin
			$display("timeout while the checker still expected commit or illegal pulses");
			$display("Test failed");
		end
		else
		begin
			for (int r = 0; r < rv32i_types::NUM_REGS; r++)
			begin
				@(posedge clk);
				#1;
				sweep_en = 1'b1;
				dbg_addr = r[4:0];
			end
			@(posedge clk);
			#1;
			sweep_en = 1'b0;
			@(posedge clk);
			$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
			if (err_count == 0 && tests_failed == 0 && tests_run == rows.size() + 1)
				$display("Test passed");
			else
				$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
rtl/rv32i_types.sv
rtl/decoder.sv
rtl/alu_exec.sv
rtl/commit_regfile.sv
rtl/op_imm_core.sv
tb/reg_checker.sv
tb/tb_op_imm_core.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_op_imm_core -f all.f || exit 1
out=$(./obj_dir/Vtb_op_imm_core)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Test passed' && exit 0 || exit 1
